/* verilog/qpu_pkg.sv */
// shared constants for the execution unit slice
// opcodes, condition codes, instruction field positions, event type

package qpu_pkg;

  parameter int XLEN      = 8;   // register width
  parameter int QUBIT_NUM = 8;   // one mask bit per qubit
  parameter int RF_NUM    = 8;   // registers per file
  parameter int RF_IDX_W  = 4;   // msb selects quantum file
  parameter int TIME_W    = 16;
  parameter int INSTR_W   = 24;
  parameter int CODE_W    = 4;   // quantum operation code

  // instruction fields
  parameter int OP_HI    = 23;
  parameter int OP_LO    = 20;
  parameter int RD_HI    = 19;
  parameter int RD_LO    = 16;
  parameter int RS_HI    = 15;
  parameter int RS_LO    = 12;
  parameter int COND_HI  = 11;
  parameter int COND_LO  = 10;
  parameter int IMM_HI   = 7;
  parameter int IMM_LO   = 0;

  typedef enum logic [3:0] {
    OP_NOP  = 4'h0,
    OP_LDI  = 4'h1,
    OP_QMOV = 4'h2,
    OP_WAIT = 4'h3,
    OP_QOP  = 4'h4,
    OP_FMR  = 4'h5
  } qpu_op_t;

  typedef enum logic [1:0] {
    COND_ALWAYS = 2'd0,
    COND_ONE    = 2'd1,
    COND_ZERO   = 2'd2,
    COND_SAME   = 2'd3   // two last results agree
  } qpu_cond_t;

  // timed quantum event, 30 bits
  typedef struct packed {
    logic [TIME_W-1:0]    timestamp;
    logic [QUBIT_NUM-1:0] mask;
    logic [CODE_W-1:0]    code;
    qpu_cond_t            cond;
  } qpu_event_t;

endpackage

/* verilog/qpu_regfile.sv */
// classical and quantum register files
// time register
// two-slot measurement store per qubit with fast feedback flags

module qpu_regfile import qpu_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  // read ports
  input  logic [RF_IDX_W-1:0]  rs1_idx,
  input  logic [RF_IDX_W-1:0]  rs2_idx,
  output logic [XLEN-1:0]      rs1_data,
  output logic [XLEN-1:0]      rs2_data,
  // classical writeback
  input  logic                 cwb_wen,
  input  logic [RF_IDX_W-1:0]  cwb_idx,
  input  logic [XLEN-1:0]      cwb_data,
  // quantum writeback
  input  logic                 qwb_wen,
  input  logic [RF_IDX_W-1:0]  qwb_idx,
  input  logic [XLEN-1:0]      qwb_data,
  // time register
  input  logic                 time_wen,
  input  logic [TIME_W-1:0]    time_data,
  output logic [TIME_W-1:0]    time_value,
  // measurement results
  input  logic                 meas_wen,
  input  logic [QUBIT_NUM-1:0] meas_data,
  input  logic [QUBIT_NUM-1:0] meas_list,
  input  logic                 fmr_en,
  output logic [QUBIT_NUM-1:0] fmr_data,
  output logic [QUBIT_NUM-1:0] meas_one,
  output logic [QUBIT_NUM-1:0] meas_zero,
  output logic [QUBIT_NUM-1:0] meas_equ
);

  localparam int SEL_W = RF_IDX_W - 1;   // register number inside a file

  logic [XLEN-1:0] crf [RF_NUM];
  logic [XLEN-1:0] qrf [RF_NUM];

  //////////////////////////////////////////////////
  // classical file

  for (genvar i = 0; i < RF_NUM; i++) begin : g_crf
    if (i == 0) begin : g_zero
      assign crf[i] = '0;   // x0 is constant zero
    end else begin : g_reg
      logic [XLEN-1:0] r;
      always_ff @(posedge clk) begin
        if (cwb_wen && (cwb_idx[SEL_W-1:0] == SEL_W'(i))) begin
          r <= cwb_data;
        end
      end
      assign crf[i] = r;
    end
  end

  //////////////////////////////////////////////////
  // quantum mask file

  for (genvar j = 0; j < RF_NUM; j++) begin : g_qrf
    if (j < QUBIT_NUM) begin : g_onehot
      assign qrf[j] = XLEN'(1) << j;   // fixed single-qubit mask
    end else begin : g_reg
      logic [XLEN-1:0] r;
      always_ff @(posedge clk) begin
        if (qwb_wen && (qwb_idx[SEL_W-1:0] == SEL_W'(j))) begin
          r <= qwb_data;
        end
      end
      assign qrf[j] = r;
    end
  end

  // msb of the index picks the quantum file
  assign rs1_data = rs1_idx[RF_IDX_W-1] ? qrf[rs1_idx[SEL_W-1:0]] : crf[rs1_idx[SEL_W-1:0]];
  assign rs2_data = rs2_idx[RF_IDX_W-1] ? qrf[rs2_idx[SEL_W-1:0]] : crf[rs2_idx[SEL_W-1:0]];

  //////////////////////////////////////////////////
  // time register

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      time_value <= '0;
    end else if (time_wen) begin
      time_value <= time_data;
    end
  end

  //////////////////////////////////////////////////
  // measurement store

  logic [QUBIT_NUM-1:0] slot0;
  logic [QUBIT_NUM-1:0] slot1;
  logic [QUBIT_NUM-1:0] meas_ptr;   // slot that takes the next result
  logic [QUBIT_NUM-1:0] meas_we;
  logic [QUBIT_NUM-1:0] we0;
  logic [QUBIT_NUM-1:0] we1;
  logic [QUBIT_NUM-1:0] latest;

  assign meas_we = meas_list & {QUBIT_NUM{meas_wen}};
  assign we0     = meas_we & ~meas_ptr;
  assign we1     = meas_we & meas_ptr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slot0    <= '1;
      slot1    <= '1;
      meas_ptr <= '0;
    end else begin
      slot0    <= (slot0 & ~we0) | (meas_data & we0);
      slot1    <= (slot1 & ~we1) | (meas_data & we1);
      meas_ptr <= meas_ptr ^ meas_we;   // alternate per written qubit
    end
  end

  // newest slot is the one not pointed at
  assign latest = (meas_ptr & slot0) | (~meas_ptr & slot1);

  // feedback flags see a result written this cycle
  assign meas_one  = (meas_we & meas_data) | (~meas_we & latest);
  assign meas_zero = ~meas_one;
  assign meas_equ  = (meas_we & ~(meas_data ^ latest)) | (~meas_we & ~(slot0 ^ slot1));

  // fmr mask comes from the rs1 read port
  assign fmr_data = latest & rs1_data[QUBIT_NUM-1:0] & {QUBIT_NUM{fmr_en}};

endmodule

/* verilog/qpu_issue.sv */
// issue stage: instruction decode and register writeback
// time register update, FMR readback
// credit-gated push of timed events toward the event queue

module qpu_issue import qpu_pkg::*; #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                 clk,
  input  logic                 rst_n,
  // instruction input
  input  logic                 instr_valid,
  input  logic [INSTR_W-1:0]   instr,
  output logic                 instr_ready,
  // regfile reads
  output logic [RF_IDX_W-1:0]  rs1_idx,
  output logic [RF_IDX_W-1:0]  rs2_idx,
  input  logic [XLEN-1:0]      rs1_data,
  input  logic [XLEN-1:0]      rs2_data,
  // regfile writebacks
  output logic                 cwb_wen,
  output logic [RF_IDX_W-1:0]  cwb_idx,
  output logic [XLEN-1:0]      cwb_data,
  output logic                 qwb_wen,
  output logic [RF_IDX_W-1:0]  qwb_idx,
  output logic [XLEN-1:0]      qwb_data,
  output logic                 time_wen,
  output logic [TIME_W-1:0]    time_data,
  input  logic [TIME_W-1:0]    time_value,
  output logic                 fmr_en,
  input  logic [QUBIT_NUM-1:0] fmr_data,
  // event queue
  output logic                 evt_push,
  output qpu_event_t           evt_data,
  input  logic                 evt_credit
);

  localparam int CRD_W = $clog2(QUEUE_DEPTH + 1);

  qpu_op_t             op;
  logic [RF_IDX_W-1:0] rd;
  logic [RF_IDX_W-1:0] rs;
  logic [7:0]          imm;
  logic                is_qop;
  logic                accept;
  logic                take;
  logic [CRD_W-1:0]    credits;

  //////////////////////////////////////////////////
  // decode

  assign op  = qpu_op_t'(instr[OP_HI:OP_LO]);
  assign rd  = instr[RD_HI:RD_LO];
  assign rs  = instr[RS_HI:RS_LO];
  assign imm = instr[IMM_HI:IMM_LO];

  assign is_qop      = (op == OP_QOP);
  assign instr_ready = !(is_qop && (credits == '0));   // stall a QOP with no credit
  assign accept      = instr_valid && instr_ready;
  assign take        = accept && is_qop;

  assign rs1_idx = rs;                       // QOP and FMR mask source
  assign rs2_idx = {1'b0, rs[RF_IDX_W-2:0]}; // QMOV always reads classical

  assign cwb_wen  = accept && ((op == OP_LDI) || (op == OP_FMR));
  assign cwb_idx  = rd;
  assign cwb_data = (op == OP_FMR) ? XLEN'(fmr_data) : imm;

  assign qwb_wen  = accept && (op == OP_QMOV);
  assign qwb_idx  = rd;
  assign qwb_data = rs2_data;

  assign time_wen  = accept && (op == OP_WAIT);
  assign time_data = time_value + TIME_W'(imm);

  assign fmr_en = (op == OP_FMR);

  //////////////////////////////////////////////////
  // credits and event push

  // a credit is reserved at acceptance, so a push never runs ahead of it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credits  <= CRD_W'(QUEUE_DEPTH);
      evt_push <= 1'b0;
    end else begin
      credits  <= credits - CRD_W'(take) + CRD_W'(evt_credit);
      evt_push <= take;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      evt_data.timestamp <= time_value;
      evt_data.mask      <= rs1_data[QUBIT_NUM-1:0];
      evt_data.code      <= imm[CODE_W-1:0];
      evt_data.cond      <= qpu_cond_t'(instr[COND_HI:COND_LO]);
    end
  end

endmodule

/* verilog/qpu_event_queue.sv */
// circular FIFO of timed events
// returns a credit to the issue stage per entry that leaves
// forwards to the dispatcher against a single dispatcher credit

module qpu_event_queue import qpu_pkg::*; #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       evt_push,
  input  qpu_event_t evt_data,
  output logic       evt_credit,
  output logic       fwd_valid,
  output qpu_event_t fwd_data,
  input  logic       fwd_credit
);

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  qpu_event_t       mem [QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             dsp_credit;   // dispatcher slot is free

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    ptr_inc = (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign fwd_valid = (count != '0) && dsp_credit;
  assign fwd_data  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (evt_push) begin
      mem[wr_ptr] <= evt_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      dsp_credit <= 1'b1;
      evt_credit <= 1'b0;
    end else begin
      if (evt_push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (fwd_valid) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      count      <= count + CNT_W'(evt_push) - CNT_W'(fwd_valid);
      evt_credit <= fwd_valid;   // one pulse per forwarded entry
      if (fwd_valid) begin
        dsp_credit <= 1'b0;
      end else if (fwd_credit) begin
        dsp_credit <= 1'b1;
      end
    end
  end

endmodule

/* verilog/qpu_event_dispatch.sv */
// event dispatcher: free-running cycle timer and one-entry holding slot
// releases the held event once its timestamp is reached
// conditional events fire only if the measurement flags agree

module qpu_event_dispatch import qpu_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 fwd_valid,
  input  qpu_event_t           fwd_data,
  output logic                 fwd_credit,
  input  logic [QUBIT_NUM-1:0] meas_one,
  input  logic [QUBIT_NUM-1:0] meas_zero,
  input  logic [QUBIT_NUM-1:0] meas_equ,
  // qubit port
  output logic                 qop_valid,
  output logic [QUBIT_NUM-1:0] qop_mask,
  output logic [CODE_W-1:0]    qop_code,
  output logic [TIME_W-1:0]    qop_time
);

  logic [TIME_W-1:0]    timer;
  logic                 slot_valid;
  qpu_event_t           slot_evt;
  logic                 release_evt;
  logic [QUBIT_NUM-1:0] cond_hit;
  logic                 fire_ok;

  //////////////////////////////////////////////////
  // condition check across the mask

  always_comb begin
    unique case (slot_evt.cond)
      COND_ONE:  cond_hit = meas_one;
      COND_ZERO: cond_hit = meas_zero;
      COND_SAME: cond_hit = meas_equ;
      default:   cond_hit = '1;   // unconditional
    endcase
  end

  // qubits outside the mask do not matter
  assign fire_ok     = &(cond_hit | ~slot_evt.mask);
  assign release_evt = slot_valid && (timer >= slot_evt.timestamp);

  //////////////////////////////////////////////////
  // timer, slot and qubit port

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      timer      <= '0;
      slot_valid <= 1'b0;
      fwd_credit <= 1'b0;
      qop_valid  <= 1'b0;
    end else begin
      timer      <= timer + 1'b1;
      fwd_credit <= release_evt;   // slot frees on fire or drop
      qop_valid  <= release_evt && fire_ok;
      if (fwd_valid) begin
        slot_valid <= 1'b1;
      end else if (release_evt) begin
        slot_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fwd_valid) begin
      slot_evt <= fwd_data;
    end
    if (release_evt) begin
      qop_mask <= slot_evt.mask;
      qop_code <= slot_evt.code;
      qop_time <= slot_evt.timestamp;
    end
  end

endmodule

/* verilog/qpu_exu_top.sv */
// execution unit slice top level
// issue stage, register file, event queue and dispatcher

module qpu_exu_top import qpu_pkg::*; #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 instr_valid,
  input  logic [INSTR_W-1:0]   instr,
  output logic                 instr_ready,
  input  logic                 meas_wen,
  input  logic [QUBIT_NUM-1:0] meas_data,
  input  logic [QUBIT_NUM-1:0] meas_list,
  output logic                 qop_valid,
  output logic [QUBIT_NUM-1:0] qop_mask,
  output logic [CODE_W-1:0]    qop_code,
  output logic [TIME_W-1:0]    qop_time
);

  // regfile side
  logic [RF_IDX_W-1:0]  rs1_idx;
  logic [RF_IDX_W-1:0]  rs2_idx;
  logic [XLEN-1:0]      rs1_data;
  logic [XLEN-1:0]      rs2_data;
  logic                 cwb_wen;
  logic [RF_IDX_W-1:0]  cwb_idx;
  logic [XLEN-1:0]      cwb_data;
  logic                 qwb_wen;
  logic [RF_IDX_W-1:0]  qwb_idx;
  logic [XLEN-1:0]      qwb_data;
  logic                 time_wen;
  logic [TIME_W-1:0]    time_data;
  logic [TIME_W-1:0]    time_value;
  logic                 fmr_en;
  logic [QUBIT_NUM-1:0] fmr_data;
  logic [QUBIT_NUM-1:0] meas_one;
  logic [QUBIT_NUM-1:0] meas_zero;
  logic [QUBIT_NUM-1:0] meas_equ;

  // event path
  logic                 evt_push;
  qpu_event_t           evt_data;
  logic                 evt_credit;
  logic                 fwd_valid;
  qpu_event_t           fwd_data;
  logic                 fwd_credit;

  qpu_issue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) issue_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .instr_ready (instr_ready),
    .rs1_idx     (rs1_idx),
    .rs2_idx     (rs2_idx),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .cwb_wen     (cwb_wen),
    .cwb_idx     (cwb_idx),
    .cwb_data    (cwb_data),
    .qwb_wen     (qwb_wen),
    .qwb_idx     (qwb_idx),
    .qwb_data    (qwb_data),
    .time_wen    (time_wen),
    .time_data   (time_data),
    .time_value  (time_value),
    .fmr_en      (fmr_en),
    .fmr_data    (fmr_data),
    .evt_push    (evt_push),
    .evt_data    (evt_data),
    .evt_credit  (evt_credit)
  );

  qpu_regfile regfile_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .rs1_idx    (rs1_idx),
    .rs2_idx    (rs2_idx),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .cwb_wen    (cwb_wen),
    .cwb_idx    (cwb_idx),
    .cwb_data   (cwb_data),
    .qwb_wen    (qwb_wen),
    .qwb_idx    (qwb_idx),
    .qwb_data   (qwb_data),
    .time_wen   (time_wen),
    .time_data  (time_data),
    .time_value (time_value),
    .meas_wen   (meas_wen),
    .meas_data  (meas_data),
    .meas_list  (meas_list),
    .fmr_en     (fmr_en),
    .fmr_data   (fmr_data),
    .meas_one   (meas_one),
    .meas_zero  (meas_zero),
    .meas_equ   (meas_equ)
  );

  qpu_event_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) queue_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .evt_push   (evt_push),
    .evt_data   (evt_data),
    .evt_credit (evt_credit),
    .fwd_valid  (fwd_valid),
    .fwd_data   (fwd_data),
    .fwd_credit (fwd_credit)
  );

  qpu_event_dispatch dispatch_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .fwd_valid  (fwd_valid),
    .fwd_data   (fwd_data),
    .fwd_credit (fwd_credit),
    .meas_one   (meas_one),
    .meas_zero  (meas_zero),
    .meas_equ   (meas_equ),
    .qop_valid  (qop_valid),
    .qop_mask   (qop_mask),
    .qop_code   (qop_code),
    .qop_time   (qop_time)
  );

endmodule

/* verification/qpu_clock_gen.sv */
// testbench clock and reset source
// period 40, reset low for the first 2 cycles

module qpu_clock_gen #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);   // release away from the active edge
    rst_n = 1'b1;
  end

endmodule

/* verification/qpu_exu_tb.sv */
// testbench for the execution unit slice
// reference model of registers, time and measurement results
// qubit port checker, watchdog, six directed and random tests

module qpu_exu_tb import qpu_pkg::*; ();

  localparam int QUEUE_DEPTH      = 4;
  localparam int CYCLES_PER_INSTR = 60;
  localparam int SLACK_CYCLES     = 200;

  logic                 clk;
  logic                 rst_n;
  logic                 instr_valid;
  logic [INSTR_W-1:0]   instr;
  logic                 instr_ready;
  logic                 meas_wen;
  logic [QUBIT_NUM-1:0] meas_data;
  logic [QUBIT_NUM-1:0] meas_list;
  logic                 qop_valid;
  logic [QUBIT_NUM-1:0] qop_mask;
  logic [CODE_W-1:0]    qop_code;
  logic [TIME_W-1:0]    qop_time;

  // reference model state
  logic [XLEN-1:0]      m_crf [RF_NUM];
  logic [XLEN-1:0]      m_qrf [RF_NUM];
  logic [TIME_W-1:0]    m_time;
  logic [QUBIT_NUM-1:0] m_latest;
  logic [QUBIT_NUM-1:0] m_prev;
  qpu_event_t           exp_q [$];   // events expected on the qubit port

  int          cycles       = 0;   // edges since reset release
  int          total_cycles = 0;
  int          n_instr      = 0;
  int          errors       = 0;
  int          tests_run    = 0;
  int          tests_failed = 0;
  logic        stall_seen   = 1'b0;
  logic [31:0] rng_state;

  qpu_clock_gen clock_gen_inst (
    .clk   (clk),
    .rst_n (rst_n)
  );

  qpu_exu_top #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) qpu_exu_top_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .instr_ready (instr_ready),
    .meas_wen    (meas_wen),
    .meas_data   (meas_data),
    .meas_list   (meas_list),
    .qop_valid   (qop_valid),
    .qop_mask    (qop_mask),
    .qop_code    (qop_code),
    .qop_time    (qop_time)
  );

  //////////////////////////////////////////////////
  // helpers and reference model

  function automatic logic [31:0] rand_next();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [INSTR_W-1:0] enc(input logic [3:0] op, input logic [3:0] rd,
                                             input logic [3:0] rs, input logic [1:0] cond,
                                             input logic [7:0] imm);
    return {op, rd, rs, cond, 2'b00, imm};
  endfunction

  // top bit of the index picks the quantum file
  function automatic logic [XLEN-1:0] read_reg(input logic [3:0] idx);
    logic [2:0] sel;
    sel = idx[2:0];
    if (idx[3]) begin
      if (int'(sel) < QUBIT_NUM) return XLEN'(1) << sel;   // fixed one-hot
      return m_qrf[sel];
    end
    if (sel == 3'd0) return '0;
    return m_crf[sel];
  endfunction

  // condition must hold on every qubit of the mask
  function automatic logic cond_met(input logic [1:0] cond, input logic [QUBIT_NUM-1:0] mask);
    logic ok;
    ok = 1'b1;
    for (int q = 0; q < QUBIT_NUM; q++) begin
      if (mask[q]) begin
        case (cond)
          COND_ONE:  ok = ok & m_latest[q];
          COND_ZERO: ok = ok & ~m_latest[q];
          COND_SAME: ok = ok & (m_latest[q] == m_prev[q]);
          default:   ok = ok;
        endcase
      end
    end
    return ok;
  endfunction

  task automatic apply_model(input logic [INSTR_W-1:0] word);
    qpu_event_t ev;
    logic [3:0] rd;
    logic [3:0] rs;
    logic [7:0] imm;
    rd  = word[RD_HI:RD_LO];
    rs  = word[RS_HI:RS_LO];
    imm = word[IMM_HI:IMM_LO];
    case (word[OP_HI:OP_LO])
      OP_LDI: if (rd[2:0] != 3'd0) m_crf[rd[2:0]] = imm;
      OP_QMOV: if (int'(rd[2:0]) >= QUBIT_NUM) m_qrf[rd[2:0]] = read_reg({1'b0, rs[2:0]});
      OP_WAIT: m_time = m_time + TIME_W'(imm);
      OP_FMR: if (rd[2:0] != 3'd0) m_crf[rd[2:0]] = m_latest & read_reg(rs);
      OP_QOP: begin
        ev.timestamp = m_time;
        ev.mask      = read_reg(rs);
        ev.code      = imm[CODE_W-1:0];
        ev.cond      = qpu_cond_t'(word[COND_HI:COND_LO]);
        if (cond_met(ev.cond, ev.mask)) exp_q.push_back(ev);   // dropped ones vanish
      end
      default: ;
    endcase
  endtask

  task automatic send(input logic [INSTR_W-1:0] word);
    n_instr++;
    @(negedge clk);
    instr_valid = 1'b1;
    instr       = word;
    @(posedge clk);
    while (!instr_ready) begin
      stall_seen = 1'b1;
      @(posedge clk);
    end
    apply_model(word);
    @(negedge clk);
    instr_valid = 1'b0;
  endtask

  task automatic write_meas(input logic [QUBIT_NUM-1:0] data, input logic [QUBIT_NUM-1:0] list);
    @(negedge clk);
    meas_wen  = 1'b1;
    meas_data = data;
    meas_list = list;
    @(negedge clk);
    meas_wen  = 1'b0;
    for (int q = 0; q < QUBIT_NUM; q++) begin
      if (list[q]) begin
        m_prev[q]   = m_latest[q];
        m_latest[q] = data[q];
      end
    end
  endtask

  // unconditional marker pushes everything older out of the pipeline
  task automatic drain();
    send(enc(OP_QOP, 4'h0, 4'hf, COND_ALWAYS, 8'h0f));
    while (exp_q.size() != 0) @(posedge clk);
  endtask

  task automatic end_test(input string name, input int err_before);
    tests_run++;
    if (errors != err_before) begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - err_before);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  //////////////////////////////////////////////////
  // qubit port checker and watchdog

  always @(posedge clk) begin : port_check
    qpu_event_t exp_evt;
    if (rst_n) begin
      if (qop_valid) begin
        assert (exp_q.size() != 0) else begin
          $display("unexpected event on the qubit port at %0t, mask %h code %h",
                   $time, qop_mask, qop_code);
          errors++;
        end
        if (exp_q.size() != 0) begin
          exp_evt = exp_q.pop_front();
          assert (qop_mask == exp_evt.mask && qop_code == exp_evt.code &&
                  qop_time == exp_evt.timestamp) else begin
            $display("MISMATCH at %0t: got mask %h code %h time %0d, want %h %h %0d",
                     $time, qop_mask, qop_code, qop_time,
                     exp_evt.mask, exp_evt.code, exp_evt.timestamp);
            errors++;
          end
          assert (cycles >= int'(exp_evt.timestamp)) else begin
            $display("MISMATCH at %0t: event for time %0d out at cycle %0d",
                     $time, exp_evt.timestamp, cycles);
            errors++;
          end
        end
      end
      cycles <= cycles + 1;
    end
  end

  always @(posedge clk) begin
    total_cycles <= total_cycles + 1;
    if (total_cycles > CYCLES_PER_INSTR * n_instr + SLACK_CYCLES) begin
      $display("timeout after %0d cycles, the DUT stopped making progress", total_cycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // stimulus

  initial begin : stimulus
    int          e0;
    logic [31:0] r;
    logic [2:0]  sel;
    instr_valid = 1'b0;
    instr       = enc(OP_QOP, 4'h0, 4'hf, COND_ALWAYS, 8'h00);   // ready then tracks credits
    meas_wen    = 1'b0;
    meas_data   = '0;
    meas_list   = '0;
    rng_state   = 32'd75532;
    m_time      = '0;
    m_latest    = '1;   // store comes out of reset all ones
    m_prev      = '1;
    for (int k = 0; k < RF_NUM; k++) begin
      m_crf[k] = '0;
      m_qrf[k] = '0;
    end
    @(posedge rst_n);

    // reset values
    e0 = errors;
    @(posedge clk);
    assert (qop_valid == 1'b0 && instr_ready == 1'b1) else begin
      $display("MISMATCH at %0t: qop_valid %b instr_ready %b after reset",
               $time, qop_valid, instr_ready);
      errors++;
    end
    end_test("reset", e0);

    // loaded masks, one-hot quantum masks, zero register
    e0 = errors;
    for (int k = 1; k < RF_NUM; k++) begin
      r = rand_next();
      send(enc(OP_LDI, 4'(k), 4'h0, COND_ALWAYS, r[7:0]));
    end
    for (int k = 0; k < 3; k++) begin
      r   = rand_next();
      sel = (r[2:0] == 3'd0) ? 3'd1 : r[2:0];
      send(enc(OP_LDI, {1'b0, sel}, 4'h0, COND_ALWAYS, r[15:8]));
      send(enc(OP_QMOV, {1'b1, sel}, {1'b0, sel}, COND_ALWAYS, 8'h00));
      send(enc(OP_QOP, 4'h0, {1'b0, sel}, COND_ALWAYS, {4'h0, r[19:16]}));
      send(enc(OP_QOP, 4'h0, {1'b1, sel}, COND_ALWAYS, {4'h0, r[23:20]}));
    end
    send(enc(OP_LDI, 4'h0, 4'h0, COND_ALWAYS, 8'hff));
    send(enc(OP_QOP, 4'h0, 4'h0, COND_ALWAYS, 8'h05));
    drain();
    end_test("masks", e0);

    // random waits, release time and order
    e0 = errors;
    for (int k = 0; k < 10; k++) begin
      r = rand_next();
      send(enc(OP_WAIT, 4'h0, 4'h0, COND_ALWAYS, {2'b00, r[5:0]}));
      send(enc(OP_QOP, 4'h0, r[11:8], COND_ALWAYS, {4'h0, r[15:12]}));
      if (r[16]) send(enc(OP_QOP, 4'h0, r[20:17], COND_ALWAYS, {4'h0, r[24:21]}));
    end
    drain();
    end_test("timing", e0);

    // far timestamp fills the queue
    e0 = errors;
    while (int'(m_time) < cycles + 150) begin
      send(enc(OP_WAIT, 4'h0, 4'h0, COND_ALWAYS, 8'hff));
    end
    stall_seen = 1'b0;
    for (int k = 0; k < QUEUE_DEPTH + 4; k++) begin
      r = rand_next();
      send(enc(OP_QOP, 4'h0, r[3:0], COND_ALWAYS, 8'(k)));
    end
    assert (stall_seen) else begin
      $display("instr_ready never dropped while the event queue was full");
      errors++;
    end
    drain();
    end_test("backpressure", e0);

    // conditional events against random measurements
    e0 = errors;
    for (int k = 0; k < 6; k++) begin
      r = rand_next();
      write_meas(r[7:0], r[15:8]);
      write_meas(r[23:16], r[31:24]);
      for (int j = 0; j < 4; j++) begin
        r = rand_next();
        send(enc(OP_QOP, 4'h0, r[5:2], r[1:0], {4'h0, r[9:6]}));
      end
      drain();
    end
    end_test("conditions", e0);

    // measurement readback into a mask
    e0 = errors;
    for (int k = 0; k < 3; k++) begin
      r = rand_next();
      write_meas(r[7:0], 8'hff);
      write_meas(r[15:8], r[23:16]);
      send(enc(OP_LDI, 4'h2, 4'h0, COND_ALWAYS, r[31:24]));
      send(enc(OP_FMR, 4'h5, 4'h2, COND_ALWAYS, 8'h00));
      send(enc(OP_QMOV, 4'hd, 4'h5, COND_ALWAYS, 8'h00));
      send(enc(OP_QOP, 4'h0, 4'hd, COND_ALWAYS, 8'h06));
      send(enc(OP_QOP, 4'h0, 4'h5, COND_ALWAYS, 8'h07));
      drain();
    end
    end_test("feedback", e0);

    $display("tests run %0d, passed %0d, failed %0d, check failures %0d",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* sources.f */
verilog/qpu_pkg.sv
verilog/qpu_regfile.sv
verilog/qpu_issue.sv
verilog/qpu_event_queue.sv
verilog/qpu_event_dispatch.sv
verilog/qpu_exu_top.sv
verification/qpu_clock_gen.sv
verification/qpu_exu_tb.sv
